//--- axi2iob.f
src/axi_pkg.sv
src/iob_pkg.sv
src/lite_if.sv
src/axi_wr_splitter.sv
src/axi_rd_splitter.sv
src/iob_bridge.sv
src/axi2iob.sv
tb/axi2iob_tb.sv

//--- run.sh
#!/bin/sh
# build and run the axi2iob testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f axi2iob.f --top-module axi2iob_tb -o axi2iob_sim \
  > build.log 2>&1 \
  && ./obj_dir/axi2iob_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- src/axi2iob.sv
// AXI4 slave to IOb master adapter top level
module axi2iob
  import axi_pkg::*, iob_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8,
  localparam int STRB_W = DATA_W / IOB_BYTE_W
) (
  input  logic              clk_i,
  input  logic              arst_i,
  // AXI4 slave port
  input  logic [ID_W-1:0]   s_axi_awid_i,
  input  logic [ADDR_W-1:0] s_axi_awaddr_i,
  input  axi_len_t          s_axi_awlen_i,
  input  axi_size_t         s_axi_awsize_i,
  input  logic              s_axi_awvalid_i,
  output logic              s_axi_awready_o,
  input  logic [DATA_W-1:0] s_axi_wdata_i,
  input  logic [STRB_W-1:0] s_axi_wstrb_i,
  input  logic              s_axi_wvalid_i,
  output logic              s_axi_wready_o,
  output logic [ID_W-1:0]   s_axi_bid_o,
  output logic              s_axi_bvalid_o,
  input  logic              s_axi_bready_i,
  input  logic [ID_W-1:0]   s_axi_arid_i,
  input  logic [ADDR_W-1:0] s_axi_araddr_i,
  input  axi_len_t          s_axi_arlen_i,
  input  axi_size_t         s_axi_arsize_i,
  input  logic              s_axi_arvalid_i,
  output logic              s_axi_arready_o,
  output logic [ID_W-1:0]   s_axi_rid_o,
  output logic [DATA_W-1:0] s_axi_rdata_o,
  output logic              s_axi_rlast_o,
  output logic              s_axi_rvalid_o,
  input  logic              s_axi_rready_i,
  // IOb master port
  output logic              iob_avalid_o,
  output logic [ADDR_W-1:0] iob_addr_o,
  output logic [DATA_W-1:0] iob_wdata_o,
  output logic [STRB_W-1:0] iob_wstrb_o,
  input  logic              iob_ready_i,
  input  logic              iob_rvalid_i,
  input  logic [DATA_W-1:0] iob_rdata_i
);

  lite_wr_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wr_lite ();
  lite_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) rd_lite ();

  axi_wr_splitter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W)) i_wr_splitter (
    .clk_i(clk_i), .arst_i(arst_i),
    .awid_i(s_axi_awid_i), .awaddr_i(s_axi_awaddr_i), .awlen_i(s_axi_awlen_i),
    .awsize_i(s_axi_awsize_i), .awvalid_i(s_axi_awvalid_i), .awready_o(s_axi_awready_o),
    .wdata_i(s_axi_wdata_i), .wstrb_i(s_axi_wstrb_i), .wvalid_i(s_axi_wvalid_i),
    .wready_o(s_axi_wready_o), .bid_o(s_axi_bid_o), .bvalid_o(s_axi_bvalid_o),
    .bready_i(s_axi_bready_i), .wr(wr_lite)
  );

  axi_rd_splitter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W)) i_rd_splitter (
    .clk_i(clk_i), .arst_i(arst_i),
    .arid_i(s_axi_arid_i), .araddr_i(s_axi_araddr_i), .arlen_i(s_axi_arlen_i),
    .arsize_i(s_axi_arsize_i), .arvalid_i(s_axi_arvalid_i), .arready_o(s_axi_arready_o),
    .rid_o(s_axi_rid_o), .rdata_o(s_axi_rdata_o), .rlast_o(s_axi_rlast_o),
    .rvalid_o(s_axi_rvalid_o), .rready_i(s_axi_rready_i), .rd(rd_lite)
  );

  iob_bridge #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_bridge (
    .clk_i(clk_i), .arst_i(arst_i), .wr(wr_lite), .rd(rd_lite),
    .iob_avalid_o(iob_avalid_o), .iob_addr_o(iob_addr_o), .iob_wdata_o(iob_wdata_o),
    .iob_wstrb_o(iob_wstrb_o), .iob_ready_i(iob_ready_i), .iob_rvalid_i(iob_rvalid_i),
    .iob_rdata_i(iob_rdata_i)
  );

endmodule

//--- src/axi_pkg.sv
// AXI burst length and size types, splitter FSM state type
package axi_pkg;

  // beats in a burst minus one
  typedef logic [7:0] axi_len_t;

  // log2 of the bytes per beat
  typedef logic [2:0] axi_size_t;

  // resp is the wait for the single-word completion
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_DATA = 2'd1,
    ST_RESP = 2'd2
  } split_state_t;

endpackage

//--- src/axi_rd_splitter.sv
// AXI4 read burst splitter into single-word read requests and R beats
module axi_rd_splitter
  import axi_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8
) (
  input  logic              clk_i,
  input  logic              arst_i,
  // read address channel
  input  logic [ID_W-1:0]   arid_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  axi_len_t          arlen_i,
  input  axi_size_t         arsize_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  // read data channel
  output logic [ID_W-1:0]   rid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rlast_o,
  output logic              rvalid_o,
  input  logic              rready_i,
  lite_rd_if.splitter       rd
);

  split_state_t      state_q;
  logic              arready_q;
  logic              rvalid_q;
  logic              rlast_q;
  logic              req_q;
  axi_len_t          count_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  axi_size_t         size_q;
  logic [DATA_W-1:0] rdata_q;
  logic              ar_fire;
  logic              beat_free;

  assign ar_fire = arvalid_i && arready_q;
  // the R register is empty next cycle
  assign beat_free = !rvalid_q || rready_i;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q   <= ST_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rlast_q   <= 1'b0;
      req_q     <= 1'b0;
      count_q   <= '0;
    end else begin
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (ar_fire) begin
            arready_q <= 1'b0;
            req_q     <= 1'b1;
            count_q   <= arlen_i;
            state_q   <= ST_DATA;
          end else begin
            arready_q <= beat_free;
          end
        end
        default: begin
          if (rd.ack) begin
            req_q    <= 1'b0;
            rvalid_q <= 1'b1;
            rlast_q  <= count_q == '0;
            if (count_q == '0) begin
              state_q <= ST_IDLE;
            end else begin
              count_q <= count_q - 1'b1;
            end
          end else if (!req_q && beat_free) begin
            // previous beat taken, fetch the next word
            req_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q   <= arid_i;
      addr_q <= araddr_i;
      size_q <= arsize_i;
    end
    if (rd.ack) begin
      rdata_q <= rd.rdata;
      addr_q  <= addr_q + (ADDR_W'(1) << size_q);
    end
  end

  assign arready_o = arready_q;
  assign rid_o     = id_q;
  assign rdata_o   = rdata_q;
  assign rlast_o   = rlast_q;
  assign rvalid_o  = rvalid_q;

  assign rd.addr = addr_q;
  assign rd.req  = req_q;

endmodule

//--- src/axi_wr_splitter.sv
// AXI4 write burst splitter into single-word write requests and one write response
module axi_wr_splitter
  import axi_pkg::*, iob_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8,
  localparam int STRB_W = DATA_W / IOB_BYTE_W
) (
  input  logic              clk_i,
  input  logic              arst_i,
  // write address channel
  input  logic [ID_W-1:0]   awid_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  axi_len_t          awlen_i,
  input  axi_size_t         awsize_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  // write data channel
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  // write response channel
  output logic [ID_W-1:0]   bid_o,
  output logic              bvalid_o,
  input  logic              bready_i,
  lite_wr_if.splitter       wr
);

  split_state_t      state_q;
  logic              awready_q;
  logic              wready_q;
  logic              bvalid_q;
  logic              req_q;
  axi_len_t          count_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  axi_size_t         size_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic              aw_fire;
  logic              w_fire;
  logic              beat_done;

  assign aw_fire   = awvalid_i && awready_q;
  assign w_fire    = wvalid_i && wready_q;
  assign beat_done = (state_q == ST_RESP) && wr.ack;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q   <= ST_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      req_q     <= 1'b0;
      count_q   <= '0;
    end else begin
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (aw_fire) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b1;
            count_q   <= awlen_i;
            state_q   <= ST_DATA;
          end else begin
            // hold off the next burst until its response is taken
            awready_q <= !bvalid_q || bready_i;
          end
        end
        ST_DATA: begin
          if (w_fire) begin
            wready_q <= 1'b0;
            req_q    <= 1'b1;
            state_q  <= ST_RESP;
          end
        end
        default: begin
          if (beat_done) begin
            req_q <= 1'b0;
            if (count_q == '0) begin
              bvalid_q <= 1'b1;
              state_q  <= ST_IDLE;
            end else begin
              count_q  <= count_q - 1'b1;
              wready_q <= 1'b1;
              state_q  <= ST_DATA;
            end
          end
        end
      endcase
    end
  end

  // burst fields and the beat held for the bridge
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_q   <= awid_i;
      addr_q <= awaddr_i;
      size_q <= awsize_i;
    end
    if (w_fire) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (beat_done) begin
      addr_q <= addr_q + (ADDR_W'(1) << size_q);
    end
  end

  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign bid_o     = id_q;
  assign bvalid_o  = bvalid_q;

  assign wr.addr  = addr_q;
  assign wr.wdata = wdata_q;
  assign wr.wstrb = wstrb_q;
  assign wr.req   = req_q;

endmodule

//--- src/iob_bridge.sv
// IOb port arbiter for single-word write and read requests
module iob_bridge
  import iob_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  localparam int STRB_W = DATA_W / IOB_BYTE_W
) (
  input  logic              clk_i,
  input  logic              arst_i,
  lite_wr_if.bridge         wr,
  lite_rd_if.bridge         rd,
  // IOb master port
  output logic              iob_avalid_o,
  output logic [ADDR_W-1:0] iob_addr_o,
  output logic [DATA_W-1:0] iob_wdata_o,
  output logic [STRB_W-1:0] iob_wstrb_o,
  input  logic              iob_ready_i,
  input  logic              iob_rvalid_i,
  input  logic [DATA_W-1:0] iob_rdata_i
);

  grant_t grant_q;
  // read address accepted, waiting for its data
  logic   rd_addr_done_q;
  logic   wr_own;
  logic   rd_own;
  logic   wr_skip;

  assign wr_own = wr.owns(grant_q);
  assign rd_own = rd.owns(grant_q);

  // all-zero strobes complete without touching the bus
  assign wr_skip = (grant_q == GNT_NONE) && wr.req && !(|wr.wstrb);

  assign iob_avalid_o = wr_own || (rd_own && !rd_addr_done_q);
  assign iob_addr_o   = wr_own ? wr.addr : rd.addr;
  assign iob_wdata_o  = wr.wdata;
  // zero strobes mark a read on IOb
  assign iob_wstrb_o  = wr_own ? wr.wstrb : '0;

  assign wr.ack   = (wr_own && iob_ready_i) || wr_skip;
  assign rd.ack   = rd_own && iob_rvalid_i;
  assign rd.rdata = iob_rdata_i;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      grant_q        <= GNT_NONE;
      rd_addr_done_q <= 1'b0;
    end else begin
      case (grant_q)
        GNT_NONE: begin
          // write wins over read
          if (wr.req) begin
            if (|wr.wstrb) begin
              grant_q <= GNT_WR;
            end
          end else if (rd.req) begin
            grant_q <= GNT_RD;
          end
        end
        GNT_WR: begin
          if (iob_ready_i) begin
            grant_q <= GNT_NONE;
          end
        end
        default: begin
          if (iob_ready_i) begin
            rd_addr_done_q <= 1'b1;
          end
          if (iob_rvalid_i) begin
            grant_q        <= GNT_NONE;
            rd_addr_done_q <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

//--- src/iob_pkg.sv
// IOb bus lane width and bridge grant type
package iob_pkg;

  // bits per strobe lane
  localparam int IOB_BYTE_W = 8;

  // owner of the IOb port
  typedef enum logic [1:0] {
    GNT_NONE = 2'd0,
    GNT_WR   = 2'd1,
    GNT_RD   = 2'd2
  } grant_t;

endpackage

//--- src/lite_if.sv
// single-word write and read request interfaces between splitters and bridge
interface lite_wr_if
  import iob_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  localparam int STRB_W = DATA_W / IOB_BYTE_W
) ();
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              req;
  logic              ack;

  // true when the bridge grant belongs to the write side
  function automatic logic owns(input grant_t g);
    return g == GNT_WR;
  endfunction

  modport splitter(output addr, output wdata, output wstrb, output req, input ack);
  modport bridge(input addr, input wdata, input wstrb, input req, output ack, import owns);
endinterface

interface lite_rd_if
  import iob_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) ();
  logic [ADDR_W-1:0] addr;
  logic              req;
  logic              ack;
  // valid in the ack cycle
  logic [DATA_W-1:0] rdata;

  function automatic logic owns(input grant_t g);
    return g == GNT_RD;
  endfunction

  modport splitter(output addr, output req, input ack, input rdata);
  modport bridge(input addr, input req, output ack, output rdata, import owns);
endinterface

//--- tb/axi2iob_tb.sv
// testbench for axi2iob with IOb memory model, shadow-memory reference and checks
module axi2iob_tb
  import axi_pkg::*;
();

  localparam int TOTAL_BEATS = 44;
  localparam int LIMIT       = TOTAL_BEATS * 40 + 200;

  logic clk_i = 1'b0;
  logic arst_i;
  logic [7:0] s_axi_awid_i, s_axi_arid_i, s_axi_bid_o, s_axi_rid_o;
  logic [31:0] s_axi_awaddr_i, s_axi_araddr_i, s_axi_wdata_i, s_axi_rdata_o;
  axi_len_t s_axi_awlen_i, s_axi_arlen_i;
  axi_size_t s_axi_awsize_i, s_axi_arsize_i;
  logic [3:0] s_axi_wstrb_i;
  logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
  logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
  logic s_axi_rlast_o, s_axi_rvalid_o, s_axi_rready_i;
  logic iob_avalid_o, iob_ready_i, iob_rvalid_i;
  logic [31:0] iob_addr_o, iob_wdata_o, iob_rdata_i;
  logic [3:0] iob_wstrb_o;

  axi2iob #(.ADDR_W(32), .DATA_W(32), .ID_W(8)) i_axi2iob (.*);

  always #20 clk_i = ~clk_i;

  int mismatches = 0;
  int failures   = 0;
  int cycles     = 0;
  int b_issued = 0, b_done = 0, r_issued = 0, r_done = 0;
  logic bp_en = 1'b0;
  logic [31:0] lfsr = 32'd96276;
  logic [31:0] mem [0:1023];
  logic [7:0] shadow [0:4095];
  logic [31:0] exp_wr_addr[$], exp_rd_addr[$], exp_rdata[$];
  logic [7:0] exp_bid[$], exp_rid[$];
  logic exp_rlast[$];

  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // initial contents, distinct for every word address
  function automatic logic [31:0] fill_word(input int idx);
    return (idx * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  function automatic logic [31:0] beat_addr(input logic [31:0] start, input int i,
                                            input axi_size_t size);
    return start + (i << size);
  endfunction

  // expected word from the byte-level shadow
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [11:0] a;
    a = {addr[11:2], 2'b00};
    return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
  endfunction

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] d,
                              input logic [3:0] s);
    logic [11:0] a;
    a = {addr[11:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
      if (s[b]) shadow[a + b] = d[8*b +: 8];
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatches++;
    $display("mismatch %s: got %h expected %h", name, got, exp);
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("error: %s", msg);
  endtask

  // IOb memory model, one access at a time
  int mstate = 0;
  int mdelay;
  logic m_is_wr;
  logic [31:0] m_rdata;

  task automatic accept_access();
    logic [9:0] idx;
    idx = iob_addr_o[11:2];
    iob_ready_i = 1'b1;
    m_is_wr = |iob_wstrb_o;
    if (m_is_wr) begin
      if (exp_wr_addr.size() == 0) report_failure("unexpected IOb write access");
      else if (exp_wr_addr[0] != iob_addr_o) report_mismatch("iob_addr_o", iob_addr_o,
                                                             exp_wr_addr[0]);
      if (exp_wr_addr.size() != 0) void'(exp_wr_addr.pop_front());
      for (int b = 0; b < 4; b++) begin
        if (iob_wstrb_o[b]) mem[idx][8*b +: 8] = iob_wdata_o[8*b +: 8];
      end
    end else begin
      if (exp_rd_addr.size() == 0) report_failure("unexpected IOb read access");
      else if (exp_rd_addr[0] != iob_addr_o) report_mismatch("iob_addr_o", iob_addr_o,
                                                             exp_rd_addr[0]);
      if (exp_rd_addr.size() != 0) void'(exp_rd_addr.pop_front());
      m_rdata = mem[idx];
    end
    mstate = 2;
  endtask

  always @(negedge clk_i) begin
    iob_ready_i  = 1'b0;
    iob_rvalid_i = 1'b0;
    if (!arst_i) begin
      if (mstate >= 2 && iob_avalid_o) report_failure("second IOb access while one is open");
      case (mstate)
        0: if (iob_avalid_o) begin
          mdelay = int'(rand_bits(2));
          if (mdelay == 0) accept_access();
          else mstate = 1;
        end
        1: begin
          mdelay--;
          if (mdelay == 0) accept_access();
        end
        2: begin
          if (m_is_wr) begin
            mstate = 0;
          end else if (rand_bits(1) == 32'd0) begin
            // read data one cycle after ready
            iob_rvalid_i = 1'b1;
            iob_rdata_i  = m_rdata;
            mstate       = 0;
          end else begin
            mstate = 3;
          end
        end
        default: begin
          iob_rvalid_i = 1'b1;
          iob_rdata_i  = m_rdata;
          mstate       = 0;
        end
      endcase
    end
  end

  // random back-pressure on the R channel
  always @(negedge clk_i) begin
    logic bit_r;
    bit_r = 1'b1;
    if (bp_en) bit_r = lfsr_step();
    s_axi_rready_i = bit_r;
  end

  // compare R beats and B responses
  logic r_hold = 1'b0;
  logic [31:0] r_held;
  always @(posedge clk_i) begin
    if (!arst_i) begin
      if (s_axi_rvalid_o) begin
        if (r_hold && s_axi_rdata_o != r_held) report_mismatch("s_axi_rdata_o stalled",
                                                               s_axi_rdata_o, r_held);
        if (s_axi_rready_i) begin
          r_hold = 1'b0;
          if (exp_rdata.size() == 0) begin
            report_failure("extra read beat");
          end else begin
            if (s_axi_rdata_o != exp_rdata[0]) report_mismatch("s_axi_rdata_o",
                                                               s_axi_rdata_o, exp_rdata[0]);
            if (s_axi_rid_o != exp_rid[0]) report_mismatch("s_axi_rid_o", s_axi_rid_o,
                                                           exp_rid[0]);
            if (s_axi_rlast_o != exp_rlast[0]) report_failure("rlast on the wrong beat");
            void'(exp_rdata.pop_front());
            void'(exp_rid.pop_front());
            void'(exp_rlast.pop_front());
          end
          r_done++;
        end else begin
          r_hold = 1'b1;
          r_held = s_axi_rdata_o;
        end
      end
      if (s_axi_bvalid_o && s_axi_bready_i) begin
        if (exp_bid.size() == 0) begin
          report_failure("extra bvalid");
        end else begin
          if (s_axi_bid_o != exp_bid[0]) report_mismatch("s_axi_bid_o", s_axi_bid_o,
                                                         exp_bid[0]);
          void'(exp_bid.pop_front());
        end
        b_done++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > LIMIT) begin
      failures++;
      $display("timeout after %0d cycles", cycles);
      $display("errors: mismatches=%0d other=%0d", mismatches, failures);
      $display("Test failed");
      $finish;
    end
  end

  task automatic write_burst(input logic [7:0] id, input logic [31:0] addr,
                             input axi_len_t len, input axi_size_t size,
                             input logic [3:0] strb, input int zero_beat);
    logic [31:0] a;
    logic [3:0] s;
    int target;
    exp_bid.push_back(id);
    b_issued++;
    target = b_issued;
    @(negedge clk_i);
    s_axi_awid_i    = id;
    s_axi_awaddr_i  = addr;
    s_axi_awlen_i   = len;
    s_axi_awsize_i  = size;
    s_axi_awvalid_i = 1'b1;
    while (!s_axi_awready_o) @(negedge clk_i);
    @(negedge clk_i);
    s_axi_awvalid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      a = beat_addr(addr, i, size);
      s = (i == zero_beat) ? 4'h0 : strb;
      s_axi_wdata_i  = rand_bits(32);
      s_axi_wstrb_i  = s;
      s_axi_wvalid_i = 1'b1;
      if (s != 4'h0) begin
        exp_wr_addr.push_back(a);
        shadow_write(a, s_axi_wdata_i, s);
      end
      while (!s_axi_wready_o) @(negedge clk_i);
      @(negedge clk_i);
      s_axi_wvalid_i = 1'b0;
    end
    while (b_done < target) @(negedge clk_i);
  endtask

  task automatic read_burst(input logic [7:0] id, input logic [31:0] addr,
                            input axi_len_t len, input axi_size_t size);
    logic [31:0] a;
    int target;
    for (int i = 0; i <= int'(len); i++) begin
      a = beat_addr(addr, i, size);
      exp_rd_addr.push_back(a);
      exp_rdata.push_back(ref_word(a));
      exp_rid.push_back(id);
      exp_rlast.push_back(i == int'(len));
    end
    r_issued += int'(len) + 1;
    target = r_issued;
    @(negedge clk_i);
    s_axi_arid_i    = id;
    s_axi_araddr_i  = addr;
    s_axi_arlen_i   = len;
    s_axi_arsize_i  = size;
    s_axi_arvalid_i = 1'b1;
    while (!s_axi_arready_o) @(negedge clk_i);
    @(negedge clk_i);
    s_axi_arvalid_i = 1'b0;
    while (r_done < target) @(negedge clk_i);
  endtask

  initial begin
    arst_i = 1'b1;
    {s_axi_awid_i, s_axi_awaddr_i, s_axi_awlen_i, s_axi_awsize_i, s_axi_awvalid_i} = '0;
    {s_axi_wdata_i, s_axi_wstrb_i, s_axi_wvalid_i} = '0;
    {s_axi_arid_i, s_axi_araddr_i, s_axi_arlen_i, s_axi_arsize_i, s_axi_arvalid_i} = '0;
    s_axi_bready_i = 1'b1;
    s_axi_rready_i = 1'b1;
    iob_ready_i    = 1'b0;
    iob_rvalid_i   = 1'b0;
    iob_rdata_i    = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(i);
      for (int b = 0; b < 4; b++) shadow[4*i + b] = mem[i][8*b +: 8];
    end
    repeat (8) @(negedge clk_i);
    arst_i = 1'b0;

    write_burst(8'h11, 32'h100, 8'd0, 3'd2, 4'hf, -1);
    read_burst(8'h21, 32'h100, 8'd0, 3'd2);
    write_burst(8'h12, 32'h200, 8'd3, 3'd2, 4'hf, -1);
    read_burst(8'h22, 32'h200, 8'd3, 3'd2);
    // partial strobes merge into the word from the first test
    write_burst(8'h13, 32'h100, 8'd0, 3'd2, 4'b0101, -1);
    read_burst(8'h23, 32'h100, 8'd0, 3'd2);
    write_burst(8'h14, 32'h300, 8'd3, 3'd2, 4'hf, 2);
    read_burst(8'h24, 32'h300, 8'd3, 3'd2);
    bp_en = 1'b1;
    read_burst(8'h25, 32'h500, 8'd7, 3'd2);
    fork
      write_burst(8'h16, 32'h600, 8'd7, 3'd2, 4'hf, -1);
      read_burst(8'h26, 32'h700, 8'd7, 3'd2);
    join
    bp_en = 1'b0;

    repeat (10) @(negedge clk_i);
    if (exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0) begin
      report_failure("expected IOb accesses never happened");
    end
    if (exp_rdata.size() != 0 || exp_bid.size() != 0) begin
      report_failure("expected AXI responses never arrived");
    end
    $display("errors: mismatches=%0d other=%0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
